// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP       := tb_chip_sim_top
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SOURCES := $(wildcard hw/*.sv hw/*.svh tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qxF '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hw/chip_macros.svh
/*
 * Chip shell constants
 * Bus widths, simulation SRAM window and software test status codes
 */

`ifndef CHIP_MACROS_SVH
`define CHIP_MACROS_SVH

// Wishbone bus widths
`define CHIP_BUS_AW 32
`define CHIP_BUS_DW 32

// Simulation SRAM depth in words and window base
`define CHIP_SRAM_WORDS 256
`define CHIP_SRAM_BASE  32'h1000_0000

// Last word of the SRAM window doubles as the status word
`define CHIP_STATUS_ADDR 32'h1000_03fc

// Codes software writes to finish a test
`define CHIP_STATUS_PASS 16'h900d
`define CHIP_STATUS_FAIL 16'hdead

`endif

// File: hw/chip_pkg.sv
/*
 * Chip shell package
 * Bundles for the Wishbone bus, the debug/SPI pads and the boot straps
 */

`default_nettype none

`include "chip_macros.svh"

package chip_pkg;

  // Wishbone classic request, master to slave
  typedef struct packed {
    logic                        cyc;
    logic                        stb;
    logic                        we;
    logic [`CHIP_BUS_AW-1:0]     adr;
    logic [`CHIP_BUS_DW-1:0]     dat;
    logic [`CHIP_BUS_DW/8-1:0]   sel;  // One bit per byte lane
  } wb_req_t;

  // Wishbone classic response, slave to master
  typedef struct packed {
    logic                    ack;
    logic [`CHIP_BUS_DW-1:0] dat;
  } wb_rsp_t;

  // JTAG host side, tdo runs the other way
  typedef struct packed {
    logic tck;
    logic tms;
    logic trst_n;
    logic tdi;
  } jtag_t;

  // SPI device host side
  typedef struct packed {
    logic sck;
    logic csb;
    logic sdi;
  } spi_t;

  // Boot straps
  typedef struct packed {
    logic jtag_spi_n;  // 1 selects JTAG on the shared pads
    logic bootstrap;
  } strap_t;

endpackage

`default_nettype wire

// File: hw/chip_sim_top.sv
/*
 * Chip shell simulation top
 * Strap sampling, shared pad mux, simulation SRAM and test status monitor
 */

`default_nettype none

module chip_sim_top (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  chip_pkg::strap_t  strap_pins_i,
  input  chip_pkg::jtag_t   jtag_i,
  input  chip_pkg::spi_t    spi_i,
  input  logic              pad_sdo_i,
  input  chip_pkg::wb_req_t wb_req_i,
  output chip_pkg::wb_rsp_t wb_rsp_o,
  output logic [7:0]        pad_o,
  output logic              tdo_o,
  output logic              spi_sdo_o,
  output logic              test_done_o,
  output logic              test_pass_o,
  output logic [15:0]       status_code_o,
  output logic              strap_valid_o
);

  chip_pkg::strap_t  straps;
  chip_pkg::wb_rsp_t sram_rsp;

  strap_sampler strap_sampler_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .strap_pins_i  (strap_pins_i),
    .straps_o      (straps),
    .strap_valid_o (strap_valid_o)
  );

  dps_pad_mux dps_pad_mux_inst (
    .straps_i      (straps),
    .strap_valid_i (strap_valid_o),
    .jtag_i        (jtag_i),
    .spi_i         (spi_i),
    .pad_sdo_i     (pad_sdo_i),
    .pad_o         (pad_o),
    .tdo_o         (tdo_o),
    .spi_sdo_o     (spi_sdo_o)
  );

  sim_sram sim_sram_inst (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wb_req_i (wb_req_i),
    .wb_rsp_o (sram_rsp)
  );

  assign wb_rsp_o = sram_rsp;

  // Status monitor snoops the same request and the SRAM ack
  sw_test_status sw_test_status_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .wb_req_i      (wb_req_i),
    .wb_ack_i      (sram_rsp.ack),
    .test_done_o   (test_done_o),
    .test_pass_o   (test_pass_o),
    .status_code_o (status_code_o)
  );

endmodule

`default_nettype wire

// File: hw/dps_pad_mux.sv
/*
 * Shared debug pad mux
 * Routes the DPS pads to JTAG or to the SPI device by the latched strap
 */

`default_nettype none

module dps_pad_mux (
  input  chip_pkg::strap_t straps_i,
  input  logic             strap_valid_i,
  input  chip_pkg::jtag_t  jtag_i,
  input  chip_pkg::spi_t   spi_i,
  input  logic             pad_sdo_i,
  output logic [7:0]       pad_o,
  output logic             tdo_o,
  output logic             spi_sdo_o
);

  logic jtag_mode;

  // SPI until the straps have been sampled
  assign jtag_mode = strap_valid_i & straps_i.jtag_spi_n;

  always_comb begin
    pad_o    = '0;  // Pad 2 is the chip output, pad 5 unused
    pad_o[0] = jtag_mode ? jtag_i.tck : spi_i.sck;
    pad_o[1] = jtag_mode ? jtag_i.tdi : spi_i.sdi;
    pad_o[3] = jtag_mode ? jtag_i.tms : spi_i.csb;

    // TAP held in reset outside JTAG mode
    pad_o[4] = jtag_mode & jtag_i.trst_n;

    pad_o[6] = straps_i.jtag_spi_n;
    pad_o[7] = straps_i.bootstrap;
  end

  // Shared data-out pad back to whichever host owns it
  assign tdo_o     = jtag_mode ? pad_sdo_i : 1'b0;
  assign spi_sdo_o = jtag_mode ? 1'b0 : pad_sdo_i;

endmodule

`default_nettype wire

// File: hw/sim_sram.sv
/*
 * Simulation SRAM
 * Wishbone classic slave with byte selects, one cycle ack,
 * reads as zero and ignores writes outside its window
 */

`default_nettype none

`include "chip_macros.svh"

module sim_sram (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  chip_pkg::wb_req_t wb_req_i,
  output chip_pkg::wb_rsp_t wb_rsp_o
);

  localparam int unsigned IDX_W = $clog2(`CHIP_SRAM_WORDS);
  localparam int unsigned NBYTE = `CHIP_BUS_DW / 8;

  logic [`CHIP_BUS_DW-1:0] mem [`CHIP_SRAM_WORDS];

  logic [`CHIP_BUS_AW-1:0] offset;
  logic [IDX_W-1:0]        idx;
  logic                    in_win;
  logic                    req_take;
  logic                    ack_q;
  logic [`CHIP_BUS_DW-1:0] rdata_q;

  // Window decode on the byte offset from the base
  assign offset = wb_req_i.adr - `CHIP_SRAM_BASE;
  assign idx    = offset[IDX_W+1:2];
  assign in_win = (wb_req_i.adr >= `CHIP_SRAM_BASE) &&
                  (offset[`CHIP_BUS_AW-1:IDX_W+2] == '0);

  // New cycle seen, not the one already being acked
  assign req_take = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_take;  // Exactly one cycle per request
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_take) begin
      if (wb_req_i.we) begin
        if (in_win) begin
          for (int b = 0; b < NBYTE; b++) begin
            if (wb_req_i.sel[b]) begin
              mem[idx][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
            end
          end
        end
      end else begin
        rdata_q <= in_win ? mem[idx] : '0;  // Outside window reads zero
      end
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdata_q;

endmodule

`default_nettype wire

// File: hw/strap_sampler.sv
/*
 * Strap sampler
 * Latches the strap pins once, on the first clock after reset release
 */

`default_nettype none

module strap_sampler (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  chip_pkg::strap_t  strap_pins_i,
  output chip_pkg::strap_t  straps_o,
  output logic              strap_valid_o
);

  chip_pkg::strap_t straps_q;
  logic             valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      straps_q <= '0;
      valid_q  <= 1'b0;
    end else if (!valid_q) begin
      // Boot-time sample only, later pin changes are ignored
      straps_q <= strap_pins_i;
      valid_q  <= 1'b1;
    end
  end

  assign straps_o      = straps_q;
  assign strap_valid_o = valid_q;

endmodule

`default_nettype wire

// File: hw/sw_test_status.sv
/*
 * Software test status monitor
 * Snoops completed bus writes to the status word for pass/fail codes
 */

`default_nettype none

`include "chip_macros.svh"

module sw_test_status (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  chip_pkg::wb_req_t wb_req_i,
  input  logic              wb_ack_i,
  output logic              test_done_o,
  output logic              test_pass_o,
  output logic [15:0]       status_code_o
);

  logic        wr_done;
  logic        status_hit;
  logic [15:0] code;
  logic        done_q;
  logic        pass_q;
  logic [15:0] code_q;

  // A write counts only in its ack cycle
  assign wr_done    = wb_req_i.cyc & wb_req_i.stb & wb_req_i.we & wb_ack_i;
  assign status_hit = wr_done && (wb_req_i.adr == `CHIP_STATUS_ADDR);
  assign code       = wb_req_i.dat[15:0];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_q <= 1'b0;
      pass_q <= 1'b0;
      code_q <= '0;
    end else if (status_hit) begin
      code_q <= code;
      if (code == `CHIP_STATUS_PASS) begin
        done_q <= 1'b1;
        pass_q <= 1'b1;
      end else if (code == `CHIP_STATUS_FAIL) begin
        done_q <= 1'b1;
        pass_q <= 1'b0;
      end
      // Any other code is just progress
    end
  end

  assign test_done_o   = done_q;
  assign test_pass_o   = pass_q;
  assign status_code_o = code_q;

endmodule

`default_nettype wire

// File: tests/tb_chip_sim_top.sv
/*
 * Chip shell testbench
 * Table-driven checks of strap latching, pad routing, SRAM and test status
 */

`default_nettype none

`include "chip_macros.svh"

module tb_chip_sim_top;
  timeunit 1ns;
  timeprecision 1ps;

  typedef enum logic [1:0] {OP_RST, OP_PAD, OP_WR, OP_RD} op_e;

  // Pad entry dat layout {straps[9:8] sdo[7] spi[6:4] jtag[3:0]}
  // Pad entry exp layout {spi_sdo[9] tdo[8] pad_o[7:0]}
  // Write entry exp is {done[17] pass[16] code[15:0]} one cycle after ack
  typedef struct packed {
    op_e         op;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
    logic        rnd;  // Take data from the LFSR
    logic [31:0] exp;
  } entry_t;

  localparam logic [31:0] BASE = `CHIP_SRAM_BASE;
  localparam logic [31:0] STAT = `CHIP_STATUS_ADDR;

  logic              clk;
  logic              rst_n;
  chip_pkg::strap_t  strap_pins;
  chip_pkg::jtag_t   jtag;
  chip_pkg::spi_t    spi;
  logic              pad_sdo;
  chip_pkg::wb_req_t wb_req;
  chip_pkg::wb_rsp_t wb_rsp;
  logic [7:0]        pad;
  logic              tdo;
  logic              spi_sdo;
  logic              test_done;
  logic              test_pass;
  logic [15:0]       status_code;
  logic              strap_valid;

  entry_t      tbl[$];
  logic [31:0] mem_model [`CHIP_SRAM_WORDS];
  logic [31:0] lfsr_state = 32'hd686;
  logic [31:0] status_prev;
  int          errors = 0;
  int          cycles = 0;
  int          limit = 0;

  chip_sim_top chip_sim_top_inst (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .strap_pins_i  (strap_pins),
    .jtag_i        (jtag),
    .spi_i         (spi),
    .pad_sdo_i     (pad_sdo),
    .wb_req_i      (wb_req),
    .wb_rsp_o      (wb_rsp),
    .pad_o         (pad),
    .tdo_o         (tdo),
    .spi_sdo_o     (spi_sdo),
    .test_done_o   (test_done),
    .test_pass_o   (test_pass),
    .status_code_o (status_code),
    .strap_valid_o (strap_valid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Fibonacci LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[30:0], lfsr_state[0]};  // One step per bit
    end
    return w;
  endfunction

  function automatic logic in_window(input logic [31:0] adr);
    return (adr >= BASE) && (adr < BASE + `CHIP_SRAM_WORDS * 4);
  endfunction

  function automatic logic [7:0] word_index(input logic [31:0] adr);
    logic [31:0] off;
    off = adr - BASE;
    return off[9:2];  // 256 words
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] adr);
    return in_window(adr) ? mem_model[word_index(adr)] : '0;
  endfunction

  task automatic model_write(input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel);
    if (in_window(adr)) begin
      for (int b = 0; b < 4; b++) begin
        if (sel[b]) mem_model[word_index(adr)][8*b +: 8] = dat[8*b +: 8];
      end
    end
  endtask

  function automatic logic [31:0] status_now();
    return 32'({test_done, test_pass, status_code});
  endfunction

  function automatic int entry_cycles(input op_e op);
    case (op)
      OP_RST:  return 6;
      OP_PAD:  return 1;
      OP_WR:   return 3;
      default: return 3;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    errors++;
    $display("error at %0t: %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
  endtask

  task automatic add_entry(input op_e op, input logic [31:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel, input logic rnd, input logic [31:0] exp);
    entry_t e;
    e = '{op, adr, dat, sel, rnd, exp};
    tbl.push_back(e);
  endtask

  task automatic build_table();
    add_entry(OP_RST, 0, 32'h3, 4'h0, 1'b0, 0);  // JTAG mode with bootstrap set
    add_entry(OP_PAD, 0, 32'h3fb, 4'h0, 1'b0, 32'h1d3);
    add_entry(OP_PAD, 0, 32'h006, 4'h0, 1'b0, 32'h0d8);  // Strap pins dropped
    add_entry(OP_PAD, 0, 32'h1dc, 4'h0, 1'b0, 32'h1c9);
    add_entry(OP_WR, BASE, 0, 4'hf, 1'b1, 0);
    add_entry(OP_WR, BASE + 32'h4, 0, 4'hf, 1'b1, 0);
    add_entry(OP_WR, BASE + 32'h4, 0, 4'h5, 1'b1, 0);
    add_entry(OP_WR, BASE + 32'h8, 0, 4'hf, 1'b1, 0);
    add_entry(OP_WR, BASE + 32'h8, 0, 4'h6, 1'b1, 0);
    add_entry(OP_WR, BASE + 32'h3f8, 0, 4'hf, 1'b1, 0);
    add_entry(OP_WR, BASE + 32'h3f8, 0, 4'h8, 1'b1, 0);
    add_entry(OP_RD, BASE, 0, 4'hf, 1'b0, 0);
    add_entry(OP_RD, BASE + 32'h4, 0, 4'hf, 1'b0, 0);
    add_entry(OP_RD, BASE + 32'h8, 0, 4'hf, 1'b0, 0);
    add_entry(OP_RD, BASE + 32'h3f8, 0, 4'hf, 1'b0, 0);
    add_entry(OP_WR, 32'h0fff_fffc, 32'hcafe_f00d, 4'hf, 1'b0, 0);
    add_entry(OP_WR, BASE + 32'h400, 0, 4'hf, 1'b1, 0);  // Would alias word 0
    add_entry(OP_RD, 32'h0fff_fffc, 0, 4'hf, 1'b0, 0);
    add_entry(OP_RD, BASE + 32'h400, 0, 4'hf, 1'b0, 0);
    add_entry(OP_RD, BASE, 0, 4'hf, 1'b0, 0);
    add_entry(OP_WR, STAT, 32'h1234, 4'hf, 1'b0, 32'h0_1234);  // Progress code only
    add_entry(OP_RD, STAT, 0, 4'hf, 1'b0, 0);
    add_entry(OP_WR, STAT, 32'hdead, 4'hf, 1'b0, 32'h2_dead);
    add_entry(OP_RST, 0, 32'h0, 4'h0, 1'b0, 0);  // SPI mode
    add_entry(OP_PAD, 0, 32'h2df, 4'h0, 1'b0, 32'h203);
    add_entry(OP_PAD, 0, 32'h320, 4'h0, 1'b0, 32'h008);
    add_entry(OP_WR, BASE + 32'h10, 0, 4'hf, 1'b1, 0);
    add_entry(OP_RD, BASE + 32'h10, 0, 4'hf, 1'b0, 0);
    add_entry(OP_RD, BASE + 32'h3f8, 0, 4'hf, 1'b0, 0);  // SRAM survives reset
    add_entry(OP_WR, STAT, 32'h900d, 4'hf, 1'b0, 32'h3_900d);
    add_entry(OP_RD, STAT, 0, 4'hf, 1'b0, 0);
  endtask

  task automatic apply_reset(input logic [1:0] straps);
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    strap_pins = straps;  // Held through reset
    wb_req = '0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    if (strap_valid !== 1'b0) report_mismatch("strap_valid_o", 0, 32'(strap_valid));
    if (wb_rsp.ack !== 1'b0) report_mismatch("wb_rsp_o.ack", 0, 32'(wb_rsp.ack));
    if (status_now() !== 32'h0) report_mismatch("test status", 0, status_now());
    @(posedge clk);
    #1;
    if (strap_valid !== 1'b1) report_mismatch("strap_valid_o", 1, 32'(strap_valid));
    status_prev = '0;
  endtask

  task automatic apply_pads(input entry_t e);
    @(posedge clk);
    #1;
    jtag = e.dat[3:0];
    spi = e.dat[6:4];
    pad_sdo = e.dat[7];
    strap_pins = e.dat[9:8];
    @(negedge clk);
    if (pad !== e.exp[7:0]) report_mismatch("pad_o", 32'(e.exp[7:0]), 32'(pad));
    if (tdo !== e.exp[8]) report_mismatch("tdo_o", 32'(e.exp[8]), 32'(tdo));
    if (spi_sdo !== e.exp[9]) report_mismatch("spi_sdo_o", 32'(e.exp[9]), 32'(spi_sdo));
  endtask

  // Raises a classic cycle and returns inside its ack cycle with the request still up
  task automatic bus_transfer(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel, output logic [31:0] rdata);
    int waits;
    @(posedge clk);
    #1;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we = we;
    wb_req.adr = adr;
    wb_req.dat = dat;
    wb_req.sel = sel;
    waits = 0;
    do begin
      @(posedge clk);
      #1;
      waits++;
    end while (wb_rsp.ack !== 1'b1 && waits < 8);
    rdata = wb_rsp.dat;
    if (wb_rsp.ack !== 1'b1) begin
      errors++;
      $display("error at %0t: bus transfer to 0x%h was never acknowledged", $time, adr);
    end else if (waits != 1) begin
      report_mismatch("ack latency", 1, 32'(waits));
    end
  endtask

  // Master drops the cycle on the edge that ends the ack cycle
  task automatic release_bus();
    @(posedge clk);
    #1;
    wb_req = '0;
    if (wb_rsp.ack !== 1'b0) report_mismatch("wb_rsp_o.ack", 0, 32'(wb_rsp.ack));
  endtask

  initial begin : stimulus
    entry_t      e;
    logic [31:0] wdat;
    logic [31:0] rdat;
    int          total;
    rst_n = 1'b0;
    strap_pins = '0;
    jtag = '0;
    spi = '0;
    pad_sdo = 1'b0;
    wb_req = '0;
    status_prev = '0;
    foreach (mem_model[i]) mem_model[i] = '0;
    build_table();
    total = 0;
    foreach (tbl[i]) total += entry_cycles(tbl[i].op);
    limit = 2 * total + 100;
    foreach (tbl[i]) begin
      e = tbl[i];
      case (e.op)
        OP_RST: apply_reset(e.dat[1:0]);
        OP_PAD: apply_pads(e);
        OP_WR: begin
          wdat = e.rnd ? rand_word() : e.dat;
          bus_transfer(1'b1, e.adr, wdat, e.sel, rdat);
          if (status_now() !== status_prev) report_mismatch("test status", status_prev,
                                                            status_now());
          model_write(e.adr, wdat, e.sel);
          release_bus();
          if (status_now() !== e.exp) report_mismatch("test status", e.exp, status_now());
          status_prev = e.exp;
        end
        OP_RD: begin
          bus_transfer(1'b0, e.adr, '0, e.sel, rdat);
          if (rdat !== model_read(e.adr)) report_mismatch("wb_rsp_o.dat", model_read(e.adr),
                                                          rdat);
          release_bus();
        end
      endcase
    end
    $display("entries: %0d  errors: %0d", tbl.size(), errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin : watchdog
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: table not finished after %0d cycles", cycles);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hw
hw/chip_pkg.sv
hw/strap_sampler.sv
hw/dps_pad_mux.sv
hw/sim_sram.sv
hw/sw_test_status.sv
hw/chip_sim_top.sv
tests/tb_chip_sim_top.sv
